/* hw/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [15:0] word_t;     // data word and address
    typedef logic [1:0]  reg_idx_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [5:0]  func_t;
    typedef logic [2:0]  alu_op_t;

    // opcodes
    localparam opcode_t OP_BNE   = 4'd0;
    localparam opcode_t OP_BEQ   = 4'd1;
    localparam opcode_t OP_ADI   = 4'd4;
    localparam opcode_t OP_ORI   = 4'd5;
    localparam opcode_t OP_LHI   = 4'd6;
    localparam opcode_t OP_LWD   = 4'd7;
    localparam opcode_t OP_SWD   = 4'd8;
    localparam opcode_t OP_JMP   = 4'd9;
    localparam opcode_t OP_JAL   = 4'd10;
    localparam opcode_t OP_RTYPE = 4'd15; // func field selects the operation

    localparam func_t FN_ADD = 6'd0;
    localparam func_t FN_SUB = 6'd1;
    localparam func_t FN_AND = 6'd2;
    localparam func_t FN_ORR = 6'd3;
    localparam func_t FN_NOT = 6'd4;
    localparam func_t FN_SHL = 6'd6;
    localparam func_t FN_SHR = 6'd7;
    localparam func_t FN_JPR = 6'd25;
    localparam func_t FN_WWD = 6'd28;
    localparam func_t FN_HLT = 6'd29;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_NOT = 3'd4;
    localparam alu_op_t ALU_SHL = 3'd5;
    localparam alu_op_t ALU_SHR = 3'd6;  // arithmetic, sign bit kept
    localparam alu_op_t ALU_LHI = 3'd7;

    localparam reg_idx_t JAL_LINK_REG = 2'd2;

endpackage

/* hw/pipe_if.sv */
// ID/EX register contents
interface idex_if import cpu_pkg::*; ();

    word_t    pc_next;
    word_t    op_a;        // rs value
    word_t    op_b;        // rt value
    word_t    imm;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;          // destination, already resolved in decode
    alu_op_t  alu_op;
    logic     alu_src_imm;
    logic     mem_read;
    logic     mem_write;
    logic     reg_write;
    logic     mem_to_reg;
    logic     is_wwd;
    logic     is_halt;
    logic     valid;

    modport src (output pc_next, op_a, op_b, imm, rs, rt, rd, alu_op, alu_src_imm,
                 mem_read, mem_write, reg_write, mem_to_reg, is_wwd, is_halt, valid);
    modport dst (input  pc_next, op_a, op_b, imm, rs, rt, rd, alu_op, alu_src_imm,
                 mem_read, mem_write, reg_write, mem_to_reg, is_wwd, is_halt, valid);

endinterface

// EX/MEM register contents
interface exmem_if import cpu_pkg::*; ();

    word_t    alu_result;
    word_t    store_data;  // rt for SWD, rs for WWD
    reg_idx_t rd;
    logic     mem_read;
    logic     mem_write;
    logic     reg_write;
    logic     mem_to_reg;
    logic     is_wwd;
    logic     is_halt;
    logic     valid;

    modport src (output alu_result, store_data, rd, mem_read, mem_write, reg_write,
                 mem_to_reg, is_wwd, is_halt, valid);
    modport dst (input  alu_result, store_data, rd, mem_read, mem_write, reg_write,
                 mem_to_reg, is_wwd, is_halt, valid);
    modport fwd (input  alu_result, rd, reg_write, mem_read);

endinterface

/* hw/fetch_stage.sv */
module fetch_stage import cpu_pkg::*; #(
    parameter word_t RESET_PC = 16'h0000
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  stall,
    input  logic  flush,
    input  logic  redirect,
    input  word_t redirect_pc,
    input  logic  halt_seen,
    input  word_t i_data,
    output logic  i_read,
    output word_t i_addr,
    output word_t if_pc,
    output word_t if_instr,
    output logic  if_valid
);

    word_t pc;
    logic  fetch_en;   // low for the first cycle out of reset

    assign i_read = fetch_en & ~halt_seen;
    assign i_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= RESET_PC;
            fetch_en <= 1'b0;
            if_valid <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (redirect)
                pc <= redirect_pc;
            else if (i_read && !stall)
                pc <= pc + 16'd1;

            // squash the slot behind a taken branch, jump or HLT
            if (flush)
                if_valid <= 1'b0;
            else if (!stall)
                if_valid <= i_read;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin  // held while decode waits
            if_pc    <= pc;
            if_instr <= i_data;
        end
    end

endmodule

/* hw/regfile.sv */
module regfile import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    input  logic     wb_en,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data,
    output word_t    rs_data,
    output word_t    rt_data
);

    word_t regs [4];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++)
                regs[i] <= '0;
        end else if (wb_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // same-cycle write shows up on the read side
    assign rs_data = (wb_en && wb_rd == rs) ? wb_data : regs[rs];
    assign rt_data = (wb_en && wb_rd == rt) ? wb_data : regs[rt];

endmodule

/* hw/decode_stage.sv */
module decode_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  word_t       if_pc,
    input  word_t       if_instr,
    input  logic        if_valid,
    input  logic        wb_en,
    input  reg_idx_t    wb_rd,
    input  word_t       wb_data,
    idex_if.src         idex,
    exmem_if.fwd        exmem,
    output logic        stall,
    output logic        flush,
    output logic        redirect,
    output word_t       redirect_pc,
    output logic        halt_seen
);

    opcode_t  opcode;
    func_t    func;
    reg_idx_t rs_idx, rt_idx, dst;
    word_t    pc_next, imm, rs_rf, rt_rf, rs_val, rt_val;
    alu_op_t  alu_op;
    logic     alu_src_imm, mem_read, mem_write, reg_write, mem_to_reg, is_wwd, is_halt;
    logic     is_branch, is_jump, is_jpr, uses_rs, uses_rt;
    logic     ex_fwd, load_use, ctrl_wait, taken, issue, go, halt_q;

    function automatic alu_op_t rtype_op(func_t f);
        case (f)
            FN_SUB:  return ALU_SUB;
            FN_AND:  return ALU_AND;
            FN_ORR:  return ALU_OR;
            FN_NOT:  return ALU_NOT;
            FN_SHL:  return ALU_SHL;
            FN_SHR:  return ALU_SHR;
            default: return ALU_ADD;
        endcase
    endfunction

    // dst is a live destination read by the current instruction
    function automatic logic reads(reg_idx_t d, logic use_a, logic use_b);
        return (use_a && d == rs_idx) || (use_b && d == rt_idx);
    endfunction

    assign opcode  = if_instr[15:12];
    assign func    = if_instr[5:0];
    assign rs_idx  = if_instr[11:10];
    assign rt_idx  = if_instr[9:8];
    assign pc_next = if_pc + 16'd1;

    always_comb begin
        imm = {{8{if_instr[7]}}, if_instr[7:0]};
        dst = if_instr[7:6];
        alu_op = ALU_ADD;
        {alu_src_imm, mem_read, mem_write, reg_write, mem_to_reg, is_wwd, is_halt} = '0;
        {is_branch, is_jump, is_jpr, uses_rs, uses_rt} = '0;
        case (opcode)
            OP_RTYPE: begin
                alu_op  = rtype_op(func);
                uses_rs = func != FN_HLT;
                case (func)
                    FN_ADD, FN_SUB, FN_AND, FN_ORR: {reg_write, uses_rt} = 2'b11;
                    FN_NOT, FN_SHL, FN_SHR:         reg_write = 1'b1;
                    FN_WWD:  is_wwd  = 1'b1;
                    FN_JPR:  is_jpr  = 1'b1;
                    FN_HLT:  is_halt = 1'b1;
                    default: uses_rs = 1'b0;
                endcase
            end
            OP_ADI, OP_ORI, OP_LHI, OP_LWD: begin
                dst = rt_idx;   // I-type writes rt
                {alu_src_imm, reg_write} = 2'b11;
                uses_rs = opcode != OP_LHI;
                if (opcode == OP_ORI) begin
                    alu_op = ALU_OR;
                    imm    = {8'h00, if_instr[7:0]};
                end
                if (opcode == OP_LHI)
                    alu_op = ALU_LHI;
                {mem_read, mem_to_reg} = {2{opcode == OP_LWD}};
            end
            OP_SWD:          {alu_src_imm, mem_write, uses_rs, uses_rt} = '1;
            OP_BNE, OP_BEQ:  {is_branch, uses_rs, uses_rt} = '1;
            OP_JMP:          is_jump = 1'b1;
            OP_JAL: begin
                {is_jump, reg_write} = '1;
                alu_op = ALU_LHI;   // LHI without immediate source selects pc_next
                dst    = JAL_LINK_REG;
            end
            default: ;
        endcase
    end

    regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rs      (rs_idx),
        .rt      (rt_idx),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .rs_data (rs_rf),
        .rt_data (rt_rf)
    );

    // EX/MEM first; write-back value comes through the regfile bypass
    assign ex_fwd = exmem.reg_write && !exmem.mem_read;
    assign rs_val = (ex_fwd && exmem.rd == rs_idx) ? exmem.alu_result : rs_rf;
    assign rt_val = (ex_fwd && exmem.rd == rt_idx) ? exmem.alu_result : rt_rf;

    always_comb begin
        load_use  = idex.mem_read && reads(idex.rd, uses_rs, uses_rt);
        // compare operands not yet available in decode
        ctrl_wait = (idex.reg_write && reads(idex.rd, is_branch | is_jpr, is_branch))
                 || (exmem.mem_read && reads(exmem.rd, is_branch | is_jpr, is_branch));
    end
    assign stall = if_valid && (load_use || ctrl_wait);
    assign issue = if_valid && !stall;

    assign taken    = is_branch && ((opcode == OP_BEQ) == (rs_val == rt_val));
    assign go       = issue && (taken || is_jump || is_jpr);
    assign redirect = go;
    assign flush    = go || (issue && is_halt);
    assign halt_seen = halt_q || (issue && is_halt);

    always_comb begin
        if (is_jpr)
            redirect_pc = rs_val;
        else if (is_jump)
            redirect_pc = {if_pc[15:12], if_instr[11:0]};
        else
            redirect_pc = pc_next + imm;   // branch offset from pc+1
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            halt_q <= 1'b0;
            {idex.mem_read, idex.mem_write, idex.reg_write, idex.mem_to_reg} <= '0;
            {idex.is_wwd, idex.is_halt, idex.valid} <= '0;
        end else begin
            halt_q          <= halt_seen;
            idex.valid      <= issue;   // bubble on stall or empty slot
            idex.mem_read   <= issue & mem_read;
            idex.mem_write  <= issue & mem_write;
            idex.reg_write  <= issue & reg_write;
            idex.mem_to_reg <= issue & mem_to_reg;
            idex.is_wwd     <= issue & is_wwd;
            idex.is_halt    <= issue & is_halt;
        end
    end

    always_ff @(posedge clk) begin
        idex.pc_next     <= pc_next;
        idex.op_a        <= rs_val;
        idex.op_b        <= rt_val;
        idex.imm         <= imm;
        idex.rs          <= rs_idx;
        idex.rt          <= rt_idx;
        idex.rd          <= dst;
        idex.alu_op      <= alu_op;
        idex.alu_src_imm <= alu_src_imm;
    end

endmodule

/* hw/execute_stage.sv */
module execute_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     wb_en,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data,
    idex_if.dst      idex,
    exmem_if.src     exmem
);

    logic  ex_fwd, link;
    word_t a_fwd, b_fwd, alu_b, alu_out;

    // loads never forward from EX/MEM, decode stalls for them
    assign ex_fwd = exmem.reg_write && !exmem.mem_read;

    assign a_fwd = (ex_fwd && exmem.rd == idex.rs) ? exmem.alu_result :
                   (wb_en && wb_rd == idex.rs)     ? wb_data : idex.op_a;
    assign b_fwd = (ex_fwd && exmem.rd == idex.rt) ? exmem.alu_result :
                   (wb_en && wb_rd == idex.rt)     ? wb_data : idex.op_b;

    assign alu_b = idex.alu_src_imm ? idex.imm : b_fwd;

    always_comb begin
        case (idex.alu_op)
            ALU_ADD: alu_out = a_fwd + alu_b;
            ALU_SUB: alu_out = a_fwd - alu_b;
            ALU_AND: alu_out = a_fwd & alu_b;
            ALU_OR:  alu_out = a_fwd | alu_b;
            ALU_NOT: alu_out = ~a_fwd;
            ALU_SHL: alu_out = {a_fwd[14:0], 1'b0};
            ALU_SHR: alu_out = {a_fwd[15], a_fwd[15:1]};
            default: alu_out = {alu_b[7:0], 8'h00};   // LHI
        endcase
    end

    assign link = idex.alu_op == ALU_LHI && !idex.alu_src_imm;  // JAL

    always_ff @(posedge clk) begin
        if (rst) begin
            {exmem.mem_read, exmem.mem_write, exmem.reg_write, exmem.mem_to_reg} <= '0;
            {exmem.is_wwd, exmem.is_halt, exmem.valid} <= '0;
        end else begin
            exmem.mem_read   <= idex.mem_read;
            exmem.mem_write  <= idex.mem_write;
            exmem.reg_write  <= idex.reg_write;
            exmem.mem_to_reg <= idex.mem_to_reg;
            exmem.is_wwd     <= idex.is_wwd;
            exmem.is_halt    <= idex.is_halt;
            exmem.valid      <= idex.valid;
        end
    end

    always_ff @(posedge clk) begin
        exmem.alu_result <= link ? idex.pc_next : alu_out;
        exmem.store_data <= idex.is_wwd ? a_fwd : b_fwd;
        exmem.rd         <= idex.rd;
    end

endmodule

/* hw/mem_wb_stage.sv */
module mem_wb_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  word_t    d_rdata,
    exmem_if.dst     exmem,
    output logic     d_read,
    output logic     d_write,
    output word_t    d_addr,
    output word_t    d_wdata,
    output logic     wb_en,
    output reg_idx_t wb_rd,
    output word_t    wb_data,
    output logic     out_valid,
    output word_t    output_port,
    output word_t    num_inst,
    output logic     is_halted
);

    logic  mem_to_reg_q, wb_valid;
    word_t load_q, alu_q;

    // data memory answers in the same cycle
    assign d_read  = exmem.mem_read;
    assign d_write = exmem.mem_write;
    assign d_addr  = exmem.alu_result;
    assign d_wdata = exmem.store_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_en        <= 1'b0;
            mem_to_reg_q <= 1'b0;
            out_valid    <= 1'b0;
            wb_valid     <= 1'b0;
            num_inst     <= '0;
            is_halted    <= 1'b0;
        end else begin
            wb_en        <= exmem.reg_write;
            mem_to_reg_q <= exmem.mem_to_reg;
            out_valid    <= exmem.is_wwd;   // one cycle per WWD
            wb_valid     <= exmem.valid;
            if (wb_valid)
                num_inst <= num_inst + 16'd1;  // retire as it leaves
            if (exmem.is_halt)
                is_halted <= 1'b1;   // sticky
        end
    end

    always_ff @(posedge clk) begin
        wb_rd       <= exmem.rd;
        load_q      <= d_rdata;
        alu_q       <= exmem.alu_result;
        output_port <= exmem.store_data;
    end

    assign wb_data = mem_to_reg_q ? load_q : alu_q;

endmodule

/* hw/cpu_top.sv */
module cpu_top import cpu_pkg::*; #(
    parameter word_t RESET_PC = 16'h0000
) (
    input  logic  clk,
    input  logic  rst,
    // instruction memory
    output logic  i_read,
    output word_t i_addr,
    input  word_t i_data,
    // data memory
    output logic  d_read,
    output logic  d_write,
    output word_t d_addr,
    output word_t d_wdata,
    input  word_t d_rdata,
    // results
    output logic  out_valid,
    output word_t output_port,
    output word_t num_inst,
    output logic  is_halted
);

    logic     stall, flush, redirect, halt_seen, if_valid;
    word_t    redirect_pc, if_pc, if_instr;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;

    idex_if  u_idex  ();
    exmem_if u_exmem ();

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (flush),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .halt_seen   (halt_seen),
        .i_data      (i_data),
        .i_read      (i_read),
        .i_addr      (i_addr),
        .if_pc       (if_pc),
        .if_instr    (if_instr),
        .if_valid    (if_valid)
    );

    decode_stage u_decode (
        .clk         (clk),
        .rst         (rst),
        .if_pc       (if_pc),
        .if_instr    (if_instr),
        .if_valid    (if_valid),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .idex        (u_idex),
        .exmem       (u_exmem),
        .stall       (stall),
        .flush       (flush),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .halt_seen   (halt_seen)
    );

    execute_stage u_execute (
        .clk     (clk),
        .rst     (rst),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .idex    (u_idex),
        .exmem   (u_exmem)
    );

    mem_wb_stage u_mem_wb (
        .clk         (clk),
        .rst         (rst),
        .d_rdata     (d_rdata),
        .exmem       (u_exmem),
        .d_read      (d_read),
        .d_write     (d_write),
        .d_addr      (d_addr),
        .d_wdata     (d_wdata),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .out_valid   (out_valid),
        .output_port (output_port),
        .num_inst    (num_inst),
        .is_halted   (is_halted)
    );

endmodule

/* bench/cpu_asserts.sv */
module cpu_asserts import cpu_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  d_read,
    input logic  d_write,
    input logic  out_valid,
    input word_t num_inst,
    input logic  is_halted
);
    timeunit 1ns;
    timeprecision 1ps;

    a_strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(d_read && d_write))
        else $error("data read and write strobes high together");

    a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
        is_halted |=> is_halted)
        else $error("is_halted dropped after rising");

    a_count_monotonic: assert property (@(posedge clk) disable iff (rst)
        num_inst >= $past(num_inst))
        else $error("num_inst went down");

    // no two WWDs ever reach write-back back to back in this program
    a_out_single: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid)
        else $error("out_valid held for more than one cycle");

endmodule

bind cpu_top cpu_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .d_read    (d_read),
    .d_write   (d_write),
    .out_valid (out_valid),
    .num_inst  (num_inst),
    .is_halted (is_halted)
);

/* bench/tb_cpu.sv */
module tb_cpu import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t RESET_PC = 16'h0000;
    localparam reg_idx_t R0 = 2'd0, R1 = 2'd1, R2 = 2'd2, R3 = 2'd3;

    logic  clk = 1'b0;
    logic  rst;
    logic  i_read, d_read, d_write, out_valid, is_halted;
    word_t i_addr, i_data, d_addr, d_wdata, d_rdata, output_port, num_inst;

    word_t       imem [256];
    word_t       dmem [256];
    word_t       ref_dmem [256];   // expected final data memory
    word_t       exp_out [$];      // expected WWD values in order
    int          ref_count, limit, out_idx, mismatches, other_errors;
    int          ref_loads, loads_seen;
    int          cycles = 0;
    logic [31:0] lfsr;
    logic [7:0]  prog_ptr;

    always #10 clk = ~clk;

    always @(posedge clk)
        cycles <= cycles + 1;

    cpu_top #(.RESET_PC(RESET_PC)) u_dut (
        .clk (clk), .rst (rst),
        .i_read (i_read), .i_addr (i_addr), .i_data (i_data),
        .d_read (d_read), .d_write (d_write), .d_addr (d_addr),
        .d_wdata (d_wdata), .d_rdata (d_rdata),
        .out_valid (out_valid), .output_port (output_port),
        .num_inst (num_inst), .is_halted (is_halted)
    );

    assign i_data  = imem[i_addr[7:0]];   // combinational reads
    assign d_rdata = dmem[d_addr[7:0]];

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output word_t val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    function automatic word_t enc_r(func_t f, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
        return {OP_RTYPE, rs, rt, rd, f};
    endfunction

    function automatic word_t enc_i(opcode_t op, reg_idx_t rs, reg_idx_t rt, logic [7:0] k);
        return {op, rs, rt, k};
    endfunction

    function automatic word_t enc_j(opcode_t op, logic [11:0] target);
        return {op, target};
    endfunction

    task automatic emit(input word_t instr);
        imem[prog_ptr] = instr;
        prog_ptr++;
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_count(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_idle(input logic in_reset);
        if (in_reset)
            check_flag(i_read, 1'b0, "i_read in reset");
        check_flag(d_read, 1'b0, "d_read");
        check_flag(d_write, 1'b0, "d_write");
        check_flag(out_valid, 1'b0, "out_valid");
        check_flag(is_halted, 1'b0, "is_halted");
        check_count(num_inst, 16'd0, "num_inst");
    endtask

    task automatic build_program();
        word_t r;
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc_r(FN_HLT, R0, R0, R0);   // anything past the program halts
            take_bits(16, r);
            dmem[i]     <= r;
            ref_dmem[i] = r;
        end
        prog_ptr = 8'd0;
        take_bits(8, r);
        emit(enc_i(OP_LHI, R0, R1, r[7:0]));
        take_bits(8, r);
        emit(enc_i(OP_ORI, R1, R1, r[7:0]));
        take_bits(8, r);
        emit(enc_i(OP_ADI, R1, R2, r[7:0]));
        emit(enc_r(FN_ADD, R1, R2, R3));       // r2 from EX/MEM and r1 from write-back
        emit(enc_r(FN_WWD, R3, R0, R0));
        emit(enc_r(FN_SUB, R3, R1, R0));
        emit(enc_r(FN_WWD, R0, R0, R0));
        emit(enc_r(FN_AND, R0, R2, R1));
        emit(enc_r(FN_WWD, R1, R0, R0));
        emit(enc_r(FN_ORR, R1, R3, R2));
        emit(enc_r(FN_WWD, R2, R0, R0));
        emit(enc_r(FN_NOT, R2, R0, R3));
        emit(enc_r(FN_WWD, R3, R0, R0));
        emit(enc_r(FN_SHL, R3, R0, R0));
        emit(enc_r(FN_WWD, R0, R0, R0));
        emit(enc_r(FN_SHR, R0, R0, R1));
        emit(enc_r(FN_WWD, R1, R0, R0));
        take_bits(8, r);
        emit(enc_i(OP_LHI, R0, R0, r[7:0]));  // base with low byte zero
        take_bits(8, r);
        emit(enc_i(OP_SWD, R0, R2, r[7:0]));
        emit(enc_i(OP_LWD, R0, R3, r[7:0]));  // same address
        emit(enc_r(FN_WWD, R3, R0, R0));       // load-use
        take_bits(8, r);
        emit(enc_i(OP_LWD, R0, R1, r[7:0]));
        emit(enc_r(FN_ADD, R1, R3, R2));
        emit(enc_r(FN_WWD, R2, R0, R0));
        take_bits(8, r);
        emit(enc_i(OP_SWD, R0, R2, r[7:0]));
        emit(enc_i(OP_BEQ, R1, R1, 8'd1));     // 25 is taken
        emit(enc_r(FN_WWD, R1, R0, R0));       // squashed
        emit(enc_i(OP_BNE, R1, R1, 8'd1));     // not taken
        emit(enc_r(FN_WWD, R2, R0, R0));
        emit(enc_i(OP_ORI, R3, R3, 8'h01));    // r3 odd and r0 even
        emit(enc_i(OP_BNE, R3, R0, 8'd1));     // taken
        emit(enc_r(FN_WWD, R3, R0, R0));       // squashed
        emit(enc_i(OP_BEQ, R3, R0, 8'd1));     // not taken
        emit(enc_r(FN_WWD, R3, R0, R0));
        emit(enc_j(OP_JMP, 12'd36));           // 34
        emit(enc_r(FN_WWD, R0, R0, R0));       // squashed
        emit(enc_j(OP_JAL, 12'd40));           // 36 links r2 = 37
        emit(enc_r(FN_WWD, R2, R0, R0));
        emit(enc_j(OP_JMP, 12'd44));
        emit(enc_r(FN_WWD, R1, R0, R0));       // squashed
        emit(enc_r(FN_WWD, R2, R0, R0));       // 40
        emit(enc_r(FN_JPR, R2, R0, R0));       // back to 37
        emit(enc_r(FN_WWD, R0, R0, R0));       // squashed
        emit(enc_r(FN_WWD, R0, R0, R0));       // skipped
        emit(enc_r(FN_WWD, R1, R0, R0));       // 44
        emit(enc_r(FN_HLT, R0, R0, R0));
        emit(enc_r(FN_WWD, R3, R0, R0));       // squashed by HLT
    endtask

    // one instruction per step without a pipeline
    function automatic void run_reference();
        word_t    regs [4];
        word_t    pc, nxt, ins, a, b, sx, addr;
        logic     halted;
        int       steps;
        for (int i = 0; i < 4; i++)
            regs[i] = '0;
        pc     = RESET_PC;
        halted = 1'b0;
        steps  = 0;
        exp_out.delete();
        ref_loads = 0;
        while (!halted && steps < 1000) begin
            ins  = imem[pc[7:0]];
            a    = regs[ins[11:10]];
            b    = regs[ins[9:8]];
            sx   = {{8{ins[7]}}, ins[7:0]};
            addr = a + sx;
            nxt  = pc + 16'd1;
            case (ins[15:12])
                OP_RTYPE: begin
                    case (ins[5:0])
                        FN_ADD:  regs[ins[7:6]] = a + b;
                        FN_SUB:  regs[ins[7:6]] = a - b;
                        FN_AND:  regs[ins[7:6]] = a & b;
                        FN_ORR:  regs[ins[7:6]] = a | b;
                        FN_NOT:  regs[ins[7:6]] = ~a;
                        FN_SHL:  regs[ins[7:6]] = a << 1;
                        FN_SHR:  regs[ins[7:6]] = word_t'($signed(a) >>> 1);
                        FN_WWD:  exp_out.push_back(a);
                        FN_JPR:  nxt = a;
                        FN_HLT:  halted = 1'b1;
                        default: ;
                    endcase
                end
                OP_ADI:  regs[ins[9:8]] = addr;
                OP_ORI:  regs[ins[9:8]] = a | {8'h00, ins[7:0]};
                OP_LHI:  regs[ins[9:8]] = {ins[7:0], 8'h00};
                OP_LWD: begin
                    regs[ins[9:8]] = ref_dmem[addr[7:0]];
                    ref_loads++;
                end
                OP_SWD:  ref_dmem[addr[7:0]] = b;
                OP_BNE:  if (a != b) nxt = nxt + sx;
                OP_BEQ:  if (a == b) nxt = nxt + sx;
                OP_JMP:  nxt = {pc[15:12], ins[11:0]};
                OP_JAL: begin
                    regs[JAL_LINK_REG] = nxt;
                    nxt = {pc[15:12], ins[11:0]};
                end
                default: ;
            endcase
            pc = nxt;
            steps++;
        end
        ref_count = steps;
    endfunction

    task automatic serve_data_writes();
        forever begin
            @(posedge clk);
            if (d_write)
                dmem[d_addr[7:0]] <= d_wdata;
        end
    endtask

    task automatic compare_outputs();
        forever begin
            @(negedge clk);
            if (!rst && d_read)
                loads_seen++;
            if (!rst && out_valid) begin
                if (out_idx < exp_out.size()) begin
                    check_word(output_port, exp_out[out_idx], "WWD output");
                end else begin
                    $display("extra output at %0t: unexpected WWD value %h", $time, output_port);
                    other_errors++;
                end
                out_idx++;
            end
        end
    endtask

    initial begin
        rst          = 1'b1;
        lfsr         = 32'hb9be;
        mismatches   = 0;
        other_errors = 0;
        out_idx      = 0;
        loads_seen   = 0;
        build_program();
        run_reference();
        limit = 3 * ref_count + 50;
        fork
            serve_data_writes();
            compare_outputs();
        join_none

        repeat (8) begin
            @(negedge clk);
            check_idle(1'b1);
        end
        rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_idle(1'b0);   // fetch runs but nothing retired yet
        end

        while (!is_halted && cycles < limit)
            @(negedge clk);
        if (!is_halted) begin
            $display("timeout: core did not halt within %0d cycles", limit);
            other_errors++;
        end else begin
            repeat (3) @(negedge clk);   // HLT retires after is_halted rises
            check_count(num_inst, word_t'(ref_count), "retired count");
            check_count(word_t'(loads_seen), word_t'(ref_loads), "load strobe cycles");
            check_flag(i_read, 1'b0, "i_read after halt");
            for (int i = 0; i < 256; i++)
                check_word(dmem[i], ref_dmem[i], $sformatf("dmem[%0d]", i));
        end
        if (out_idx != exp_out.size()) begin
            $display("missing output: saw %0d of %0d WWD values", out_idx, exp_out.size());
            other_errors++;
        end

        $display("%0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* verilog.f */
hw/cpu_pkg.sv
hw/pipe_if.sv
hw/fetch_stage.sv
hw/regfile.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/cpu_top.sv
bench/cpu_asserts.sv
bench/tb_cpu.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_cpu -f verilog.f

run: compile
	@out="$$(./obj_dir/Vtb_cpu)"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
